//--- ex_stim.txt
# name op reg1 reg2 wd wreg | expected: wdata wreg hi lo (all hex)
# lines are issued back to back; hi and lo are the values once the op has finished
and_rr 24 f0f01234 0ff0ff00 01 1 00f01200 1 00000000 00000000
or_rr 25 f0f00000 00001234 02 1 f0f01234 1 00000000 00000000
xor_rr 26 ffff0000 0f0f0f0f 03 1 f0f00f0f 1 00000000 00000000
nor_rr 27 f0f00000 000000ff 04 1 0f0fff00 1 00000000 00000000
sll 00 00000004 00000013 05 1 00000130 1 00000000 00000000
srl 02 00000008 800000f0 06 1 00800000 1 00000000 00000000
sra 03 00000008 800000f0 07 1 ff800000 1 00000000 00000000
add_ovf 20 7fffffff 00000001 08 1 80000000 0 00000000 00000000
addu_wrap 21 7fffffff 00000001 09 1 80000000 1 00000000 00000000
sub_ovf 22 80000000 00000001 0a 1 7fffffff 0 00000000 00000000
subu_wrap 23 80000000 00000001 0b 1 7fffffff 1 00000000 00000000
add_ok 20 00000005 fffffffd 0c 1 00000002 1 00000000 00000000
slt_neg 2a ffffffff 00000001 0d 1 00000001 1 00000000 00000000
sltu_neg 2b ffffffff 00000001 0e 1 00000000 1 00000000 00000000
clz_zero 30 00000000 00000000 0f 1 00000020 1 00000000 00000000
clz_ones 30 ffffffff 00000000 10 1 00000000 1 00000000 00000000
clz_two 30 00000002 00000000 11 1 0000001e 1 00000000 00000000
clo_ones 31 ffffffff 00000000 12 1 00000020 1 00000000 00000000
clo_low 31 fffffffd 00000000 13 1 0000001e 1 00000000 00000000
mult_neg 18 fffffffe 00000003 00 0 00000000 0 ffffffff fffffffa
multu_neg 19 fffffffe 00000003 00 0 00000000 0 00000002 fffffffa
mul_low 32 fffffffe 00000007 14 1 fffffff2 1 00000002 fffffffa
mthi 11 12345678 00000000 00 0 00000000 0 12345678 fffffffa
mtlo 13 9abcdef0 00000000 00 0 00000000 0 12345678 9abcdef0
mfhi 10 00000000 00000000 15 1 12345678 1 12345678 9abcdef0
mflo 12 00000000 00000000 16 1 9abcdef0 1 12345678 9abcdef0
movz 0a cafe0001 00000000 17 1 cafe0001 1 12345678 9abcdef0
movn 0b 0000beef 00000001 18 1 0000beef 1 12345678 9abcdef0

//--- verilog.f
ex_pkg.sv
ex_issue_reg.sv
ex_mul.sv
ex_alu.sv
ex_writeback.sv
ex_top.sv
tb_clk_gen.sv
ex_properties.sv
tb_ex.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ex_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_ex -o tb_ex_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb_ex.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ex;

    import ex_pkg::*;

    localparam int MAX_TESTS      = 64;
    localparam int RESET_TIMEOUT  = 32;
    localparam int RESULT_TIMEOUT = 32;

    logic      clk;
    logic      rst_n;
    ex_issue_t issue_i;
    ex_wb_t    wb_o;
    word_t     hi_o;
    word_t     lo_o;

    string       names [MAX_TESTS];
    logic [5:0]  op_mem [MAX_TESTS];
    word_t       reg1_mem [MAX_TESTS];
    word_t       reg2_mem [MAX_TESTS];
    reg_addr_t   wd_mem [MAX_TESTS];
    logic        wreg_mem [MAX_TESTS];
    word_t       exp_wdata [MAX_TESTS];
    logic        exp_wreg [MAX_TESTS];
    word_t       exp_hi [MAX_TESTS];
    word_t       exp_lo [MAX_TESTS];

    int n_tests;
    int tests_passed;
    int tests_failed;
    int fail_checks;
    bit aborted;

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (4)
    ) tb_clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_top ex_top_inst (
        .clk     (clk),
        .rst_n_i (rst_n),
        .issue_i (issue_i),
        .wb_o    (wb_o),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    bind ex_top ex_properties ex_properties_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .wb_i    (wb_o)
    );

    task automatic load_stim();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] t_op;
        logic [31:0] t_reg1;
        logic [31:0] t_reg2;
        logic [31:0] t_wd;
        logic [31:0] t_wreg;
        logic [31:0] t_wdata;
        logic [31:0] t_ewreg;
        logic [31:0] t_hi;
        logic [31:0] t_lo;
        n_tests = 0;
        fd = $fopen("ex_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file ex_stim.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, t_op, t_reg1,
                               t_reg2, t_wd, t_wreg, t_wdata, t_ewreg, t_hi, t_lo);
                if (code != 10) begin
                    $display("malformed stimulus line: %0s", line);
                    aborted = 1'b1;
                    continue;
                end
                names[n_tests]     = name;
                op_mem[n_tests]    = t_op[5:0];
                reg1_mem[n_tests]  = t_reg1;
                reg2_mem[n_tests]  = t_reg2;
                wd_mem[n_tests]    = t_wd[REG_ADDR_W-1:0];
                wreg_mem[n_tests]  = t_wreg[0];
                exp_wdata[n_tests] = t_wdata;
                exp_wreg[n_tests]  = t_ewreg[0];
                exp_hi[n_tests]    = t_hi;
                exp_lo[n_tests]    = t_lo;
                n_tests++;
            end
            $fclose(fd);
        end
    endtask

    // one op per rising edge, back to back
    task automatic drive_all();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            aborted = 1'b1;
        end else begin
            for (int i = 0; i < n_tests; i++) begin
                @(posedge clk);
                issue_i.valid <= 1'b1;
                issue_i.op    <= aluop_e'(op_mem[i]);
                issue_i.reg1  <= reg1_mem[i];
                issue_i.reg2  <= reg2_mem[i];
                issue_i.wd    <= wd_mem[i];
                issue_i.wreg  <= wreg_mem[i];
            end
            @(posedge clk);
            issue_i.valid <= 1'b0;
        end
    endtask

    task automatic wait_result(output bit ok, output int waited);
        waited = 0;
        @(posedge clk);
        while (wb_o.valid !== 1'b1 && waited < RESULT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        ok = (wb_o.valid === 1'b1);
    endtask

    task automatic check_result(input int i, input int waited);
        int   errs_before;
        logic exp_ovf;
        errs_before = fail_checks;
        // a requested write that comes back cleared is an overflow
        exp_ovf = wreg_mem[i] & ~exp_wreg[i];
        // after the first result the stream has no gaps
        assert (i == 0 || waited == 0) else begin
            $display("result of test %0s came %0d cycles after the previous one",
                     names[i], waited + 1);
            fail_checks++;
        end
        assert (wb_o.wdata == exp_wdata[i]) else begin
            $display("MISMATCH %0s wdata expected %h actual %h",
                     names[i], exp_wdata[i], wb_o.wdata);
            fail_checks++;
        end
        assert (wb_o.wreg == exp_wreg[i]) else begin
            $display("MISMATCH %0s wreg expected %0b actual %0b",
                     names[i], exp_wreg[i], wb_o.wreg);
            fail_checks++;
        end
        assert (wb_o.ovf == exp_ovf) else begin
            $display("MISMATCH %0s ovf expected %0b actual %0b",
                     names[i], exp_ovf, wb_o.ovf);
            fail_checks++;
        end
        assert (wb_o.wd == wd_mem[i]) else begin
            $display("MISMATCH %0s wd expected %h actual %h", names[i], wd_mem[i], wb_o.wd);
            fail_checks++;
        end
        assert (hi_o == exp_hi[i]) else begin
            $display("MISMATCH %0s hi expected %h actual %h", names[i], exp_hi[i], hi_o);
            fail_checks++;
        end
        assert (lo_o == exp_lo[i]) else begin
            $display("MISMATCH %0s lo expected %h actual %h", names[i], exp_lo[i], lo_o);
            fail_checks++;
        end
        if (fail_checks == errs_before) begin
            tests_passed++;
            $display("test %0s ok", names[i]);
        end else begin
            tests_failed++;
            $display("test %0s failed", names[i]);
        end
    endtask

    // results pair with issued lines in order
    task automatic collect_all();
        bit ok;
        int waited;
        for (int i = 0; i < n_tests; i++) begin
            wait_result(ok, waited);
            if (!ok) begin
                $display("timeout waiting for the result of test %0s", names[i]);
                tests_failed++;
                aborted = 1'b1;
                break;
            end
            check_result(i, waited);
        end
        if (!aborted) begin
            repeat (4) begin
                @(posedge clk);
                assert (!wb_o.valid) else begin
                    $display("extra result seen after the last test");
                    fail_checks++;
                end
            end
        end
    endtask

    initial begin
        issue_i = '0;
        tests_passed = 0;
        tests_failed = 0;
        fail_checks = 0;
        aborted = 1'b0;
        load_stim();
        fork
            drive_all();
            collect_all();
        join
        $display("tests run %0d, passed %0d, failed %0d", n_tests, tests_passed, tests_failed);
        if (!aborted && fail_checks == 0 && n_tests > 0 && tests_passed == n_tests) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_properties.sv
`timescale 1ns/1ns
`default_nettype none

module ex_properties (
    input wire                    clk,
    input wire                    rst_n_i,
    input wire ex_pkg::ex_issue_t issue_i,
    input wire ex_pkg::ex_wb_t    wb_i
);

    // fixed two cycle latency, in both directions
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_i.valid == $past(issue_i.valid, 2)
    ) else $error("result strobe does not follow the issue strobe by two cycles");

    quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n_i |=> (!wb_i.valid && !wb_i.wreg)
    ) else $error("result valid or register write during reset");

    // overflow never writes the register file
    ovf_blocks_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_i.ovf |-> !wb_i.wreg
    ) else $error("register write raised together with overflow");

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released on a rising edge, after RESET_CYCLES edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module ex_top (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire ex_pkg::ex_issue_t issue_i,
    output ex_pkg::ex_wb_t         wb_o,
    output ex_pkg::word_t          hi_o,
    output ex_pkg::word_t          lo_o
);

    import ex_pkg::*;

    ex_stage_t stage;
    dword_t    prod_s;
    dword_t    prod_u;
    ex_wb_t    alu_wb;
    hilo_upd_t hilo_upd;

    // first register, op and operands
    ex_issue_reg ex_issue_reg_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .stage_o (stage)
    );

    ex_mul ex_mul_inst (
        .stage_i  (stage),
        .prod_s_o (prod_s),
        .prod_u_o (prod_u)
    );

    // hi/lo come back from the output side
    ex_alu ex_alu_inst (
        .stage_i  (stage),
        .prod_s_i (prod_s),
        .prod_u_i (prod_u),
        .hi_i     (hi_o),
        .lo_i     (lo_o),
        .wb_o     (alu_wb),
        .hilo_o   (hilo_upd)
    );

    // second register, result and hi/lo
    ex_writeback ex_writeback_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (alu_wb),
        .hilo_i  (hilo_upd),
        .wb_o    (wb_o),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

endmodule

`default_nettype wire

//--- ex_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module ex_writeback (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire ex_pkg::ex_wb_t    wb_i,
    input  wire ex_pkg::hilo_upd_t hilo_i,
    output ex_pkg::ex_wb_t         wb_o,
    output ex_pkg::word_t          hi_o,
    output ex_pkg::word_t          lo_o
);

    import ex_pkg::*;

    logic hilo_we;

    // only a live op may touch hi/lo
    assign hilo_we = wb_i.valid & hilo_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o.valid <= 1'b0;
            wb_o.wreg  <= 1'b0;
            wb_o.ovf   <= 1'b0;
        end else begin
            wb_o.valid <= wb_i.valid;
            wb_o.wd    <= wb_i.wd;
            // overflowed add or sub must not reach the register file
            wb_o.wreg  <= wb_i.wreg & ~wb_i.ovf;
            wb_o.wdata <= wb_i.wdata;
            wb_o.ovf   <= wb_i.ovf;
        end
    end

    // written on the same edge as the result, so the next op sees it
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (hilo_we) begin
            hi_o <= hilo_i.hi;
            lo_o <= hilo_i.lo;
        end
    end

endmodule

`default_nettype wire

//--- ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
    input  wire ex_pkg::ex_stage_t stage_i,
    input  wire ex_pkg::dword_t    prod_s_i,
    input  wire ex_pkg::dword_t    prod_u_i,
    input  wire ex_pkg::word_t     hi_i,
    input  wire ex_pkg::word_t     lo_i,
    output ex_pkg::ex_wb_t         wb_o,
    output ex_pkg::hilo_upd_t      hilo_o
);

    import ex_pkg::*;

    // count of zero bits above the first one, WORD_W for zero
    function automatic word_t lead_zeros(input word_t v);
        word_t n;
        logic  found;
        n = word_t'(WORD_W);
        found = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                n = word_t'(WORD_W - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    word_t                a;
    word_t                b;
    logic [SHAMT_W-1:0]   shamt;
    word_t                sum;
    word_t                diff;
    word_t                logic_res;
    word_t                shift_res;
    word_t                arith_res;
    word_t                move_res;
    logic                 ovf;

    assign a     = stage_i.reg1;
    assign b     = stage_i.reg2;
    assign shamt = a[SHAMT_W-1:0];
    assign sum   = a + b;
    assign diff  = a - b;

    // immediate forms arrive here already in reg2
    always_comb begin
        case (stage_i.op)
            OP_AND:  logic_res = a & b;
            OP_OR:   logic_res = a | b;
            OP_XOR:  logic_res = a ^ b;
            OP_NOR:  logic_res = ~(a | b);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (stage_i.op)
            OP_SLL:  shift_res = b << shamt;
            OP_SRL:  shift_res = b >> shamt;
            OP_SRA:  shift_res = word_t'($signed(b) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        ovf = 1'b0;
        case (stage_i.op)
            OP_ADD: begin
                arith_res = sum;
                ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
            end
            OP_SUB: begin
                arith_res = diff;
                ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);
            end
            OP_ADDU: arith_res = sum;
            OP_SUBU: arith_res = diff;
            OP_SLT:  arith_res = word_t'($signed(a) < $signed(b));
            OP_SLTU: arith_res = word_t'(a < b);
            OP_CLZ:  arith_res = lead_zeros(a);
            OP_CLO:  arith_res = lead_zeros(~a);
            default: arith_res = '0;
        endcase
    end

    // movz and movn condition is resolved before issue
    always_comb begin
        case (stage_i.op)
            OP_MOVZ, OP_MOVN: move_res = a;
            OP_MFHI:          move_res = hi_i;
            OP_MFLO:          move_res = lo_i;
            default:          move_res = '0;
        endcase
    end

    always_comb begin
        wb_o.valid = stage_i.valid;
        wb_o.wd    = stage_i.wd;
        wb_o.wreg  = stage_i.wreg;
        wb_o.ovf   = stage_i.valid & ovf;
        case (stage_i.res_class)
            RES_LOGIC: wb_o.wdata = logic_res;
            RES_SHIFT: wb_o.wdata = shift_res;
            RES_MOVE:  wb_o.wdata = move_res;
            RES_ARITH: wb_o.wdata = arith_res;
            RES_MUL:   wb_o.wdata = prod_s_i[WORD_W-1:0];
            default:   wb_o.wdata = '0;
        endcase
    end

    // hi/lo update, the half that is not written keeps its value
    always_comb begin
        hilo_o.we = 1'b1;
        hilo_o.hi = hi_i;
        hilo_o.lo = lo_i;
        case (stage_i.op)
            OP_MULT: begin
                hilo_o.hi = prod_s_i[2*WORD_W-1:WORD_W];
                hilo_o.lo = prod_s_i[WORD_W-1:0];
            end
            OP_MULTU: begin
                hilo_o.hi = prod_u_i[2*WORD_W-1:WORD_W];
                hilo_o.lo = prod_u_i[WORD_W-1:0];
            end
            OP_MTHI: hilo_o.hi = a;
            OP_MTLO: hilo_o.lo = a;
            default: hilo_o.we = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- ex_mul.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mul (
    input  wire ex_pkg::ex_stage_t stage_i,
    output ex_pkg::dword_t         prod_s_o,
    output ex_pkg::dword_t         prod_u_o
);

    import ex_pkg::*;

    word_t  mag1;
    word_t  mag2;
    logic   neg;
    dword_t prod_mag;

    // magnitudes of the two's complement operands
    assign mag1 = stage_i.reg1[WORD_W-1] ? (~stage_i.reg1 + 1'b1) : stage_i.reg1;
    assign mag2 = stage_i.reg2[WORD_W-1] ? (~stage_i.reg2 + 1'b1) : stage_i.reg2;

    assign neg = stage_i.reg1[WORD_W-1] ^ stage_i.reg2[WORD_W-1];

    assign prod_mag = dword_t'(mag1) * dword_t'(mag2);

    // signs differ so the product is negative
    assign prod_s_o = neg ? (~prod_mag + 1'b1) : prod_mag;

    assign prod_u_o = dword_t'(stage_i.reg1) * dword_t'(stage_i.reg2);

endmodule

`default_nettype wire

//--- ex_issue_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_issue_reg (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire ex_pkg::ex_issue_t issue_i,
    output ex_pkg::ex_stage_t   stage_o
);

    import ex_pkg::*;

    // which result mux leg the op selects
    function automatic res_class_e decode_class(input aluop_e op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR:
                return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:
                return RES_SHIFT;
            OP_MOVZ, OP_MOVN, OP_MFHI, OP_MFLO:
                return RES_MOVE;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:
                return RES_ARITH;
            OP_MUL:
                return RES_MUL;
            default:
                return RES_NONE;
        endcase
    endfunction

    res_class_e issue_class;

    assign issue_class = decode_class(issue_i.op);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end else begin
            stage_o.valid     <= issue_i.valid;
            stage_o.op        <= issue_i.op;
            stage_o.reg1      <= issue_i.reg1;
            stage_o.reg2      <= issue_i.reg2;
            stage_o.wd        <= issue_i.wd;
            stage_o.wreg      <= issue_i.wreg;
            stage_o.res_class <= issue_class;
        end
    end

endmodule

`default_nettype wire

//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // mostly the MIPS funct codes, special2 ops moved to 0x30 and up
    typedef enum logic [5:0] {
        OP_SLL   = 6'h00,
        OP_SRL   = 6'h02,
        OP_SRA   = 6'h03,
        OP_MOVZ  = 6'h0A,
        OP_MOVN  = 6'h0B,
        OP_MFHI  = 6'h10,
        OP_MTHI  = 6'h11,
        OP_MFLO  = 6'h12,
        OP_MTLO  = 6'h13,
        OP_MULT  = 6'h18,
        OP_MULTU = 6'h19,
        OP_ADD   = 6'h20,
        OP_ADDU  = 6'h21,
        OP_SUB   = 6'h22,
        OP_SUBU  = 6'h23,
        OP_AND   = 6'h24,
        OP_OR    = 6'h25,
        OP_XOR   = 6'h26,
        OP_NOR   = 6'h27,
        OP_SLT   = 6'h2A,
        OP_SLTU  = 6'h2B,
        OP_CLZ   = 6'h30,
        OP_CLO   = 6'h31,
        OP_MUL   = 6'h32,
        OP_NOP   = 6'h3F
    } aluop_e;

    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_MOVE  = 3'd3,
        RES_ARITH = 3'd4,
        RES_MUL   = 3'd5
    } res_class_e;

    typedef struct packed {
        logic      valid;
        aluop_e    op;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_issue_t;

    // issue fields with the result class already decoded
    typedef struct packed {
        logic       valid;
        aluop_e     op;
        word_t      reg1;
        word_t      reg2;
        reg_addr_t  wd;
        logic       wreg;
        res_class_e res_class;
    } ex_stage_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        logic      ovf;
    } ex_wb_t;

    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_upd_t;

endpackage

`default_nettype wire
